// ==== compile.f ====
source/osd_pkg.sv
source/osd_cmd_decoder.sv
source/osd_raster_timer.sv
source/osd_bitmap_ram.sv
source/osd_blender.sv
source/osd_overlay.sv
dv/osd_sva.sv
dv/osd_tb.sv

// ==== dv/osd_tb.sv ====
/* OSD overlay testbench: clock, reset, host command tasks, video source,
   reference model and per-cycle compare of pix_out and amix */
`timescale 1ns/1ps
`default_nettype none

module osd_tb;
	import osd_pkg::*;

	localparam logic [2:0]  TINT  = 3'd4;
	localparam logic [11:0] X_OFF = 12'd0;
	localparam logic [11:0] Y_OFF = 12'd0;
	localparam int ACT   = 320;
	localparam int HBL   = 40;
	localparam int LINES = 90;
	localparam int VBL   = 1400;
	localparam int FRAME_CYC  = LINES * (ACT + HBL) + VBL;
	localparam int HOST_WORDS = 4096 + 96 + 100;
	localparam int LIMIT = 8 * FRAME_CYC + 4 * HOST_WORDS;

	logic       clk_video = 1'b0;
	logic       rst;
	logic       io_osd;
	logic       io_strobe;
	osd_param_u io_din;
	osd_pix_t   pix_in;
	osd_pix_t   pix_out;
	logic [1:0] amix;

	// Reference model state
	logic [7:0]  ref_mem [0:4095];
	logic        ref_en = 1'b0;
	logic        en_pend = 1'b0;
	logic        ref_info = 1'b0;
	logic        info_pend = 1'b0;
	int          ref_x = 0;
	int          ref_y = 0;
	int          ref_w = 0;
	int          ref_h = 0;
	logic [1:0]  ref_amix = 2'd0;
	logic [11:0] wr_ptr = 12'd0;
	logic [7:0]  cur_cmd = 8'd0;
	int          word_idx = 0;
	logic        fr_en = 1'b0;
	int          fr_lines = 0;
	int          prev_lines = 0;
	int          line_width = 0;
	osd_pix_t    exp_now = '0;
	osd_pix_t    exp_q [$];
	logic        checking = 1'b0;
	int          cycles = 0;
	int          n_checks = 0;
	int          n_errors = 0;
	int          test_err0 = 0;
	int          n_tests = 0;

	osd_overlay #(
		.OSD_COLOR(TINT),
		.OSD_X_OFFSET(X_OFF),
		.OSD_Y_OFFSET(Y_OFF)
	) UUT (
		.clk_video, .rst, .io_osd, .io_strobe, .io_din,
		.pix_in, .pix_out, .amix
	);

	always #5 clk_video = ~clk_video;

	always @(posedge clk_video) begin
		cycles++;
		if (cycles > LIMIT) begin
			$display("Timeout after %0d cycles, test sequence did not finish", cycles);
			$display("sim failed");
			$finish;
		end
	end

	// Expected output for one input sample at column c, row r
	function automatic osd_pix_t ref_pixel(input osd_pix_t p, input int c, input int r);
		int         xs;
		int         ys;
		int         ww;
		int         hh;
		int         lc;
		int         lr;
		logic [7:0] b;
		logic       bv;
		osd_pix_t   q;
		q = p;
		if (ref_info) begin
			xs = ref_x;
			ys = ref_y;
			ww = ref_w;
			hh = ref_h;
		end else begin
			xs = (line_width - 256) / 2 + int'(X_OFF);
			ys = (fr_lines - 64) / 2 + int'(Y_OFF);
			ww = 256;
			hh = 64;
		end
		lc = c - xs;
		lr = r - ys;
		if (fr_en && p.de && lc >= 0 && lr >= 0 && lc < ww && lr < hh) begin
			b = ref_mem[((lr / 8) % 16) * 256 + lc % 256];
			bv = b[lr % 8];
			q.rgb = {bv, bv, TINT[2], p.rgb[23:19], bv, bv, TINT[1], p.rgb[15:11],
				bv, bv, TINT[0], p.rgb[7:3]};
		end
		return q;
	endfunction

	// Host word as the DUT sees it
	function automatic void model_word(input osd_param_u w);
		if (word_idx == 0) begin
			cur_cmd = w.raw[7:0];
		end else if (cur_cmd == CMD_MIX) begin
			ref_amix = w.raw[1:0];
		end else if (cur_cmd == CMD_ENABLE) begin
			case (word_idx)
				1: begin
					en_pend = w.ctrl.enable;
					info_pend = w.ctrl.info;
				end
				2: ref_x = w.raw[11:0];
				3: ref_y = w.raw[11:0];
				4: ref_w = w.size.size * 8;
				5: ref_h = w.size.size * 8;
				default: ;
			endcase
		end else if (cur_cmd == CMD_WRITE) begin
			if (word_idx == 4) begin
				wr_ptr = {w.raw[3:0], 8'h00};
			end else if (word_idx > 4) begin
				ref_mem[wr_ptr] = w.raw[7:0];
				wr_ptr = wr_ptr + 12'd1;
			end
		end
		word_idx++;
	endfunction

	task automatic check_pix(input osd_pix_t got, input osd_pix_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Mismatch pix_out: got %h expected %h at %0t", got, exp, $time);
		end
	endtask

	task automatic check_mix(input logic [1:0] got, input logic [1:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Mismatch amix: got %h expected %h at %0t", got, exp, $time);
		end
	endtask

	always @(negedge clk_video) begin
		if (checking) begin
			exp_q.push_back(exp_now);
			if (exp_q.size() > 2)
				check_pix(pix_out, exp_q.pop_front());
			check_mix(amix, ref_amix);
		end
	end

	task automatic drive_pix(input logic de, input int c, input int r);
		osd_pix_t p;
		p.de = de;
		p.rgb = 24'($urandom);
		@(posedge clk_video);
		#1;
		pix_in = p;
		exp_now = ref_pixel(p, c, r);
	endtask

	task automatic run_frame();
		int r;
		int c;
		fr_en = ref_en;
		fr_lines = prev_lines;
		for (r = 0; r < LINES; r++) begin
			for (c = 0; c < HBL; c++)
				drive_pix(1'b0, 0, r);
			for (c = 0; c < ACT; c++)
				drive_pix(1'b1, c, r);
			line_width = ACT;
		end
		prev_lines = LINES;
		for (c = 0; c < VBL; c++)
			drive_pix(1'b0, 0, 0);
	endtask

	task automatic begin_xfer();
		@(posedge clk_video);
		#1;
		io_osd = 1'b1;
		word_idx = 0;
	endtask

	task automatic end_xfer();
		@(posedge clk_video);
		#1;
		io_osd = 1'b0;
		@(posedge clk_video);
		#1;
		if (cur_cmd == CMD_ENABLE) begin
			ref_en = en_pend;
			ref_info = info_pend;
		end
	endtask

	task automatic send_word(input osd_param_u w);
		@(posedge clk_video);
		#1;
		io_din = w;
		io_strobe = 1'b1;
		@(posedge clk_video);
		#1;
		io_strobe = 1'b0;
		model_word(w);
	endtask

	task automatic set_window(input logic en, input logic info, input int x, input int y,
		input int wsz, input int hsz);
		osd_param_u ctl;
		ctl = '0;
		ctl.ctrl.enable = en;
		ctl.ctrl.info = info;
		begin_xfer();
		send_word(16'(CMD_ENABLE));
		send_word(ctl);
		send_word(16'(x));
		send_word(16'(y));
		send_word(16'(wsz));
		send_word(16'(hsz));
		end_xfer();
	endtask

	// Three ignored words, the page word, then data
	task automatic write_bitmap(input logic [3:0] page, input int count);
		begin_xfer();
		send_word(16'(CMD_WRITE));
		repeat (3) send_word(16'($urandom));
		send_word({12'h000, page});
		repeat (count) send_word(16'($urandom));
		end_xfer();
	endtask

	task automatic set_mix(input logic [15:0] w);
		begin_xfer();
		send_word(16'(CMD_MIX));
		send_word(w);
		end_xfer();
	endtask

	task automatic stray_strobes();
		repeat (4) begin
			@(posedge clk_video);
			#1;
			io_din.raw = 16'($urandom);
			io_strobe = 1'b1;
			@(posedge clk_video);
			#1;
			io_strobe = 1'b0;
		end
	endtask

	task automatic finish_test(input string name);
		int errs;
		errs = n_errors + UUT.u_sva.n_fail;
		n_tests++;
		if (errs == test_err0)
			$display("test %0d %s: ok", n_tests, name);
		else
			$display("test %0d %s: %0d errors", n_tests, name, errs - test_err0);
		test_err0 = errs;
	endtask

	initial begin
		void'($urandom(3145));
		rst = 1'b1;
		io_osd = 1'b0;
		io_strobe = 1'b0;
		io_din = '0;
		pix_in = '0;
		repeat (8) @(posedge clk_video);
		#1;
		rst = 1'b0;
		repeat (2) @(posedge clk_video);
		checking = 1'b1;

		run_frame();
		finish_test("pass-through while disabled");

		write_bitmap(4'h0, 4096);
		set_window(1'b1, 1'b0, 0, 0, 0, 0);
		run_frame();
		finish_test("centred window");

		set_window(1'b1, 1'b1, 40, 10, 12, 5);
		run_frame();
		finish_test("explicit window");

		write_bitmap(4'h5, 96);
		set_window(1'b1, 1'b0, 0, 0, 0, 0);
		run_frame();
		finish_test("page write");

		set_mix(16'hA5F6);
		check_mix(amix, 2'b10);
		set_window(1'b1, 1'b0, 0, 0, 0, 0);
		stray_strobes();
		check_mix(amix, 2'b10);
		finish_test("mix select");

		set_window(1'b0, 1'b0, 0, 0, 0, 0);
		run_frame();
		finish_test("disable");

		$display("%0d tests, %0d checks, %0d errors", n_tests, n_checks,
			n_errors + UUT.u_sva.n_fail);
		if (n_errors + UUT.u_sva.n_fail == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/osd_sva.sv ====
/* Bound checks on OSD overlay outputs: video latency and mix register */
`timescale 1ns/1ps
`default_nettype none

module osd_sva (
	input logic              clk_video,
	input logic              rst,
	input logic              io_osd,
	input logic              io_strobe,
	input osd_pkg::osd_pix_t pix_in,
	input osd_pkg::osd_pix_t pix_out,
	input logic [1:0]        amix
);
	import osd_pkg::*;

	// Count of failed assertions
	int n_fail = 0;

	// Data enable passes with two cycles of latency
	a_de_delay: assert property (@(posedge clk_video) disable iff (rst)
		pix_out.de == $past(pix_in.de, 2))
		else begin
			n_fail++;
			$error("de_out does not follow de_in by two cycles");
		end

	a_amix_known: assert property (@(posedge clk_video) disable iff (rst)
		!$isunknown(amix))
		else begin
			n_fail++;
			$error("amix is unknown after reset");
		end

	// No transfer open, so a strobe is ignored
	a_amix_idle: assert property (@(posedge clk_video) disable iff (rst)
		(!io_osd && $rose(io_strobe)) |=> $stable(amix))
		else begin
			n_fail++;
			$error("amix changed on a strobe outside a transfer");
		end

endmodule

bind osd_overlay osd_sva u_sva (
	.clk_video(clk_video), .rst(rst), .io_osd(io_osd), .io_strobe(io_strobe),
	.pix_in(pix_in), .pix_out(pix_out), .amix(amix)
);

`default_nettype wire

// ==== source/osd_overlay.sv ====
/* OSD overlay top: decoder, raster timer, bitmap memory, blender */
`timescale 1ns/1ps
`default_nettype none

module osd_overlay #(
	parameter logic [2:0]  OSD_COLOR    = 3'd4,
	parameter logic [11:0] OSD_X_OFFSET = 12'd0,
	parameter logic [11:0] OSD_Y_OFFSET = 12'd0
) (
	input  logic                clk_video,
	input  logic                rst,
	input  logic                io_osd,
	input  logic                io_strobe,
	input  osd_pkg::osd_param_u io_din,
	input  osd_pkg::osd_pix_t   pix_in,
	output osd_pkg::osd_pix_t   pix_out,
	output logic [1:0]          amix
);
	import osd_pkg::*;

	osd_wr_t     wr;
	osd_geom_t   geom;
	logic [11:0] rd_addr;
	logic [2:0]  bit_sel;
	logic        in_window;
	logic [7:0]  rd_data;

	osd_cmd_decoder u_decoder (
		.clk_video, .rst, .io_osd, .io_strobe, .io_din,
		.wr, .geom, .amix
	);

	osd_raster_timer #(
		.OSD_X_OFFSET(OSD_X_OFFSET),
		.OSD_Y_OFFSET(OSD_Y_OFFSET)
	) u_timer (
		.clk_video, .rst, .de(pix_in.de), .geom,
		.rd_addr, .bit_sel, .in_window
	);

	osd_bitmap_ram u_ram (
		.clk_video, .wr, .rd_addr, .rd_data
	);

	osd_blender #(
		.OSD_COLOR(OSD_COLOR)
	) u_blender (
		.clk_video, .rst, .pix_in, .in_window, .bit_sel, .rd_data, .pix_out
	);

endmodule

`default_nettype wire

// ==== source/osd_blender.sv ====
/* Bitmap bit selection and tint mix into the delayed pixel */
`timescale 1ns/1ps
`default_nettype none

module osd_blender #(
	parameter logic [2:0] OSD_COLOR = 3'd4
) (
	input  logic              clk_video,
	input  logic              rst,
	input  osd_pkg::osd_pix_t pix_in,
	input  logic              in_window,
	input  logic [2:0]        bit_sel,
	input  logic [7:0]        rd_data,
	output osd_pkg::osd_pix_t pix_out
);
	import osd_pkg::*;

	osd_pix_t   pix_d;
	logic       win_d;
	logic [2:0] sel_d;
	logic       osd_bit;
	logic [23:0] mixed;

	assign osd_bit = rd_data[sel_d];

	// Per channel: bit, bit, tint, then top five source bits
	assign mixed = {{osd_bit, osd_bit, OSD_COLOR[2], pix_d.rgb[23:19]},
	                {osd_bit, osd_bit, OSD_COLOR[1], pix_d.rgb[15:11]},
	                {osd_bit, osd_bit, OSD_COLOR[0], pix_d.rgb[7:3]}};

	always_ff @(posedge clk_video) begin
		if (rst) begin
			pix_d.de   <= 1'b0;
			win_d      <= 1'b0;
			pix_out.de <= 1'b0;
		end else begin
			pix_d   <= pix_in;
			win_d   <= in_window;
			sel_d   <= bit_sel;
			pix_out <= '{de: pix_d.de, rgb: win_d ? mixed : pix_d.rgb};
		end
	end

endmodule

`default_nettype wire

// ==== source/osd_bitmap_ram.sv ====
/* 4096x8 OSD bitmap, one write port and one registered read port */
`timescale 1ns/1ps
`default_nettype none

module osd_bitmap_ram (
	input  logic             clk_video,
	input  osd_pkg::osd_wr_t wr,
	input  logic [11:0]      rd_addr,
	output logic [7:0]       rd_data
);
	import osd_pkg::*;

	logic [7:0] mem [0:4095];

	always_ff @(posedge clk_video) begin
		if (wr.valid)
			mem[wr.addr] <= wr.data;
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// ==== source/osd_raster_timer.sv ====
/* Raster position tracking, line width and frame height measurement,
   window placement and bitmap read address */
`timescale 1ns/1ps
`default_nettype none

module osd_raster_timer #(
	parameter logic [11:0] OSD_X_OFFSET = 12'd0,
	parameter logic [11:0] OSD_Y_OFFSET = 12'd0
) (
	input  logic               clk_video,
	input  logic               rst,
	input  logic               de,
	input  osd_pkg::osd_geom_t geom,
	output logic [11:0]        rd_addr,
	output logic [2:0]         bit_sel,
	output logic               in_window
);
	import osd_pkg::*;

	logic        de_d;
	logic [11:0] col_q;
	logic [11:0] row_q;
	logic [11:0] width_q;
	logic [11:0] lines_q;
	logic [15:0] blank_q;
	logic        en_q;

	logic        line_start;
	logic        frame_start;
	logic [11:0] col_cur;
	logic [11:0] row_cur;
	logic [11:0] width_cur;
	logic [11:0] lines_cur;
	logic        en_cur;
	logic [11:0] ctr_x;
	logic [11:0] ctr_y;
	logic [11:0] x_start;
	logic [11:0] y_start;
	logic [11:0] win_w;
	logic [11:0] win_h;
	logic [11:0] loc_c;
	logic [11:0] loc_r;

	assign line_start = de & ~de_d;

	// Previous line width is still in the column counter at line start
	assign width_cur   = line_start ? col_q : width_q;
	assign frame_start = line_start & (blank_q > {2'b00, width_cur, 2'b00});

	assign col_cur   = line_start ? 12'd0 : col_q;
	assign row_cur   = frame_start ? 12'd0 : (line_start ? row_q + 12'd1 : row_q);
	assign lines_cur = frame_start ? row_q + 12'd1 : lines_q;
	assign en_cur    = frame_start ? geom.enable : en_q;

	always_ff @(posedge clk_video) begin
		if (rst) begin
			de_d    <= 1'b0;
			col_q   <= 12'd0;
			row_q   <= 12'd0;
			width_q <= 12'd0;
			lines_q <= 12'd0;
			blank_q <= 16'd0;
			en_q    <= 1'b0;
		end else begin
			de_d    <= de;
			col_q   <= col_cur + {11'd0, de};
			row_q   <= row_cur;
			width_q <= width_cur;
			lines_q <= lines_cur;
			en_q    <= en_cur;
			if (de)
				blank_q <= 16'd0;
			else if (~&blank_q)
				blank_q <= blank_q + 16'd1;
		end
	end

	// Centred placement from measured raster size
	assign ctr_x = ((width_cur - OSD_DEF_W) >> 1) + OSD_X_OFFSET;
	assign ctr_y = ((lines_cur - OSD_DEF_H) >> 1) + OSD_Y_OFFSET;

	assign x_start = geom.info ? geom.x : ctr_x;
	assign y_start = geom.info ? geom.y : ctr_y;
	assign win_w   = geom.info ? {3'd0, geom.w} : OSD_DEF_W;
	assign win_h   = geom.info ? {3'd0, geom.h} : OSD_DEF_H;

	assign loc_c = col_cur - x_start;
	assign loc_r = row_cur - y_start;

	assign in_window = en_cur & de
		& (col_cur >= x_start) & (row_cur >= y_start)
		& (loc_c < win_w) & (loc_r < win_h);

	// 16 bands of 8 rows, 256 bytes each
	assign rd_addr = {loc_r[6:3], loc_c[7:0]};
	assign bit_sel = loc_r[2:0];

endmodule

`default_nettype wire

// ==== source/osd_cmd_decoder.sv ====
/* Host command parser: bitmap writes, window geometry and mix setting */
`timescale 1ns/1ps
`default_nettype none

module osd_cmd_decoder (
	input  logic                   clk_video,
	input  logic                   rst,
	input  logic                   io_osd,
	input  logic                   io_strobe,
	input  osd_pkg::osd_param_u    io_din,
	output osd_pkg::osd_wr_t       wr,
	output osd_pkg::osd_geom_t     geom,
	output logic [1:0]             amix
);
	import osd_pkg::*;

	typedef enum logic [1:0] {ST_IDLE, ST_CMD, ST_PRE, ST_DATA} state_t;

	state_t      state;
	osd_cmd_e    cmd;
	logic        strobe_d;
	logic        strobe_rise;
	logic        data_word;
	logic [1:0]  pcnt;
	logic [11:0] bcnt;
	logic        en_pend;
	logic        info_pend;
	logic        geom_en;
	logic        geom_info;
	logic [11:0] geom_x;
	logic [11:0] geom_y;
	logic [8:0]  geom_w;
	logic [8:0]  geom_h;
	logic        wr_valid;
	logic [11:0] wr_addr;
	logic [7:0]  wr_data;

	assign strobe_rise = io_osd & io_strobe & ~strobe_d;
	assign data_word   = strobe_rise & (state == ST_DATA);

	always_ff @(posedge clk_video) begin
		if (rst) begin
			state     <= ST_IDLE;
			cmd       <= CMD_WRITE;
			strobe_d  <= 1'b0;
			pcnt      <= 2'd0;
			bcnt      <= 12'd0;
			en_pend   <= 1'b0;
			info_pend <= 1'b0;
			geom_en   <= 1'b0;
			geom_info <= 1'b0;
			amix      <= 2'd0;
			wr_valid  <= 1'b0;
		end else begin
			strobe_d <= io_strobe;
			wr_valid <= 1'b0;
			if (!io_osd) begin
				// End of transfer, enable and info take effect here
				if (state != ST_IDLE && cmd == CMD_ENABLE) begin
					geom_en   <= en_pend;
					geom_info <= info_pend;
				end
				state <= ST_IDLE;
				pcnt  <= 2'd0;
				bcnt  <= 12'd0;
			end else begin
				case (state)
					ST_IDLE, ST_CMD: begin
						state <= ST_CMD;
						if (strobe_rise) begin
							cmd   <= osd_cmd_e'(io_din.raw[7:0]);
							bcnt  <= 12'd0;
							pcnt  <= 2'd0;
							state <= (io_din.raw[7:0] == CMD_WRITE) ? ST_PRE : ST_DATA;
						end
					end
					ST_PRE: if (strobe_rise) begin
						pcnt <= pcnt + 2'd1;
						// Fourth word carries the address page
						if (pcnt == 2'd3) begin
							bcnt  <= {io_din.raw[3:0], 8'h00};
							state <= ST_DATA;
						end
					end
					ST_DATA: if (strobe_rise) begin
						bcnt <= bcnt + 12'd1;
						if (cmd == CMD_WRITE)
							wr_valid <= 1'b1;
						if (cmd == CMD_MIX)
							amix <= io_din.raw[1:0];
						if (cmd == CMD_ENABLE && bcnt == 12'd0) begin
							en_pend   <= io_din.ctrl.enable;
							info_pend <= io_din.ctrl.info;
						end
					end
					default: state <= ST_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge clk_video) begin
		if (data_word) begin
			wr_addr <= bcnt;
			wr_data <= io_din.raw[7:0];
			if (cmd == CMD_ENABLE) begin
				case (bcnt)
					12'd1: geom_x <= io_din.raw[11:0];
					12'd2: geom_y <= io_din.raw[11:0];
					12'd3: geom_w <= {io_din.size.size, 3'b000};
					12'd4: geom_h <= {io_din.size.size, 3'b000};
					default: ;
				endcase
			end
		end
	end

	assign wr = '{valid: wr_valid, addr: wr_addr, data: wr_data};
	assign geom = '{enable: geom_en, info: geom_info, x: geom_x, y: geom_y,
		w: geom_w, h: geom_h};

endmodule

`default_nettype wire

// ==== source/osd_pkg.sv ====
/* Shared OSD definitions: command codes, host parameter word views,
   window geometry, bitmap write and video sample structs */
`default_nettype none

package osd_pkg;

	typedef enum logic [7:0] {
		CMD_WRITE  = 8'h0C,
		CMD_ENABLE = 8'h28,
		CMD_MIX    = 8'h74
	} osd_cmd_e;

	// One host word, decoded per command
	typedef union packed {
		logic [15:0] raw;
		struct packed {
			logic [12:0] unused;
			logic        info;
			logic        unused1;
			logic        enable;
		} ctrl;
		struct packed {
			logic [9:0] unused;
			logic [5:0] size;
		} size;
	} osd_param_u;

	typedef struct packed {
		logic        enable;
		logic        info;
		logic [11:0] x;
		logic [11:0] y;
		logic [8:0]  w;
		logic [8:0]  h;
	} osd_geom_t;

	typedef struct packed {
		logic        valid;
		logic [11:0] addr;
		logic [7:0]  data;
	} osd_wr_t;

	typedef struct packed {
		logic        de;
		logic [23:0] rgb;
	} osd_pix_t;

	// Centred window size
	localparam logic [11:0] OSD_DEF_W = 12'd256;
	localparam logic [11:0] OSD_DEF_H = 12'd64;

endpackage

`default_nettype wire
